// ==== Makefile ====
# Verilator build and run for the lane controller testbench

VERILATOR ?= verilator
TOP       ?= laneControllerTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build outputs"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== src/ctrlPipe.sv ====
/*
  Execute, Memory and Writeback control registers with stall/flush,
  struct narrowing per stage and branch resolution in Execute
*/
`timescale 1ns/1ps

module ctrlPipe (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stallD,     // Decode holds its instruction
  input  logic                flushD,     // Decode slot becomes a bubble
  input  logic                stallE,
  input  logic                flushE,
  input  logic                stallM,
  input  logic                flushM,
  input  logic                stallW,
  input  logic                flushW,
  input  ctrlPkg::decodeCtrlT ctrlD,
  input  logic [1:0]          flagsE,     // {eq, lt} from the comparator
  output ctrlPkg::decodeCtrlT exCtrl,
  output ctrlPkg::memCtrlT    memCtrl,
  output ctrlPkg::wbCtrlT     wbCtrl,
  output logic                pcSrcE      // Redirect fetch
);
  import ctrlPkg::*;

  logic       validD;                     // Decode slot holds a real instruction
  decodeCtrlT exNext;
  memCtrlT    memNext;
  wbCtrlT     wbNext;
  logic       eqE;
  logic       ltE;
  logic       branchFlag;
  logic       takenE;

  ////////////////////////////////////////////////////////////
  // Decode occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      validD <= 1'b0;
    end else if (!stallD) begin
      validD <= 1'b1;                     // Next fetched word enters Decode
    end
  end

  assign exNext = validD ? ctrlD : '0;    // Flushed Decode slot enters Execute as a bubble

  ////////////////////////////////////////////////////////////
  // Stage registers, flush wins over stall
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      exCtrl <= '0;
    end else if (!stallE) begin
      exCtrl <= exNext;
    end
  end

  // Memory keeps only what the LSU and later stages need
  assign memNext = '{
    regWrite:  exCtrl.regWrite,
    memRead:   exCtrl.memRead,
    memWrite:  exCtrl.memWrite,
    resultSrc: exCtrl.resultSrc,
    funct3:    exCtrl.funct3,
    rd:        exCtrl.rd,
    valid:     exCtrl.valid
  };

  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      memCtrl <= '0;
    end else if (!stallM) begin
      memCtrl <= memNext;
    end
  end

  assign wbNext = '{
    regWrite:  memCtrl.regWrite,
    resultSrc: memCtrl.resultSrc,
    rd:        memCtrl.rd
  };

  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      wbCtrl <= '0;
    end else if (!stallW) begin
      wbCtrl <= wbNext;
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////

  assign eqE        = flagsE[1];
  assign ltE        = flagsE[0];
  assign branchFlag = exCtrl.funct3[2] ? ltE : eqE;   // blt/bge/bltu/bgeu use lt
  assign takenE     = branchFlag ^ exCtrl.funct3[0];  // bne, bge, bgeu invert
  assign pcSrcE     = exCtrl.jump | (exCtrl.branch & takenE);

  // A flushed stage carries a bubble on the following cycle
  assert property (@(posedge clk) disable iff (!rstN) flushE |=> !exCtrl.valid)
    else $error("Execute still valid after flush");
  assert property (@(posedge clk) disable iff (!rstN) flushM |=> !memCtrl.valid)
    else $error("Memory still valid after flush");
  assert property (@(posedge clk) disable iff (!rstN) flushW |=> !wbCtrl.regWrite)
    else $error("Writeback still writes after flush");  // No valid bit in Writeback

endmodule

// ==== src/ctrlPkg.sv ====
/*
  Shared lane-controller types: register index, opcode and select
  enums, and the control structs carried down the pipeline
*/
package ctrlPkg;

  typedef logic [4:0] regAddrT;           // Architectural register index, x0 reads as zero

  // RV32I major opcodes handled by this lane
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opOpImm  = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opOp     = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111
  } opcodeE;

  typedef enum logic [2:0] {
    immI = 3'b000,                        // 12-bit signed, loads and ALU immediates
    immS = 3'b001,                        // Split store offset
    immB = 3'b010,                        // Branch offset, bit 0 implied
    immJ = 3'b011,                        // Jump offset
    immU = 3'b100                         // Upper 20 bits
  } immSrcE;

  typedef enum logic [2:0] {
    resAlu     = 3'b000,
    resMem     = 3'b001,
    resPcPlus4 = 3'b010                   // Link address for jal/jalr
  } resultSrcE;

  typedef enum logic [1:0] {
    fwdNone = 2'b00,                      // Operand from the register file
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSelE;

  ////////////////////////////////////////////////////////////
  // Per-stage control words
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       regWrite;
    immSrcE     immSrc;
    logic       aluSrcA;                  // 1 selects PC
    logic       aluSrcB;                  // 1 selects immediate
    logic       memRead;
    logic       memWrite;
    resultSrcE  resultSrc;
    logic       branch;
    logic       jump;
    logic       aluOp;                    // 0 for address add, 1 decodes funct3
    logic       subArith;                 // sub, sra, slt, sltu
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddrT    rs1;
    regAddrT    rs2;
    regAddrT    rd;
    logic       valid;
  } decodeCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    resultSrcE  resultSrc;
    logic [2:0] funct3;                   // Access size and sign for the LSU
    regAddrT    rd;
    logic       valid;
  } memCtrlT;

  typedef struct packed {
    logic      regWrite;
    resultSrcE resultSrc;
    regAddrT   rd;
  } wbCtrlT;

  // One other lane's destination in a given stage
  typedef struct packed {
    regAddrT rd;
    logic    regWrite;
  } laneWrT;

endpackage

// ==== src/hazardUnit.sv ====
/*
  Operand forwarding selection across the lanes of a bundle
  and the load-use stall for Decode
*/
`timescale 1ns/1ps

module hazardUnit #(
  parameter int NumLanes = 4              // Lanes in the bundle, this one included
) (
  input  ctrlPkg::decodeCtrlT               ctrlD,
  input  ctrlPkg::decodeCtrlT               exCtrl,
  input  ctrlPkg::memCtrlT                  memCtrl,
  input  ctrlPkg::wbCtrlT                   wbCtrl,
  input  ctrlPkg::laneWrT [NumLanes-2:0]    otherMem,  // Other lanes in Memory
  input  ctrlPkg::laneWrT [NumLanes-2:0]    otherWb,   // Other lanes in Writeback
  output ctrlPkg::fwdSelE                   fwdA,
  output ctrlPkg::fwdSelE                   fwdB,
  output logic [$clog2(NumLanes)-1:0]       laneSelA,  // 0 is this lane
  output logic [$clog2(NumLanes)-1:0]       laneSelB,
  output logic                              loadStallD
);
  import ctrlPkg::*;

  localparam int SelW = $clog2(NumLanes);

  logic matchDE;                          // Decode source hits the Execute destination

  // Lowest priority first, so each later hit overrides
  function automatic void pickSource(
    input  regAddrT         rs,
    output fwdSelE          sel,
    output logic [SelW-1:0] lane
  );
    sel  = fwdNone;
    lane = '0;
    if (rs != '0) begin                   // x0 is never forwarded
      for (int k = NumLanes - 2; k >= 0; k--) begin
        if (otherWb[k].regWrite && (otherWb[k].rd == rs)) begin
          sel  = fwdWb;
          lane = SelW'(k + 1);
        end
      end
      if (wbCtrl.regWrite && (wbCtrl.rd == rs)) begin
        sel  = fwdWb;
        lane = '0;
      end
      for (int k = NumLanes - 2; k >= 0; k--) begin
        if (otherMem[k].regWrite && (otherMem[k].rd == rs)) begin
          sel  = fwdMem;
          lane = SelW'(k + 1);
        end
      end
      if (memCtrl.regWrite && (memCtrl.rd == rs)) begin
        sel  = fwdMem;                    // Own Memory stage is the newest
        lane = '0;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Forwarding for the Execute sources
  ////////////////////////////////////////////////////////////

  always_comb begin
    pickSource(exCtrl.rs1, fwdA, laneSelA);
    pickSource(exCtrl.rs2, fwdB, laneSelB);
  end

  // Load result arrives too late to forward into Execute
  assign matchDE    = (exCtrl.rd != '0) &&
                      ((exCtrl.rd == ctrlD.rs1) || (exCtrl.rd == ctrlD.rs2));
  assign loadStallD = exCtrl.memRead & matchDE;

  always_comb begin
    assert final (!((exCtrl.rs1 == '0) && (fwdA != fwdNone)))
      else $error("rs1 of x0 selected a forwarded operand");
    assert final (!((exCtrl.rs2 == '0) && (fwdB != fwdNone)))
      else $error("rs2 of x0 selected a forwarded operand");
  end

endmodule

// ==== src/instrDecoder.sv ====
/*
  RV32I base decoder with exact funct3/funct7 checks,
  control word selection per opcode and the illegal flag
*/
`timescale 1ns/1ps

module instrDecoder (
  input  logic [31:0]         instr,      // Instruction in Decode
  output ctrlPkg::decodeCtrlT ctrl,       // Decoded controls, zero when illegal
  output logic                illegal
);
  import ctrlPkg::*;

  opcodeE     opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       funct7Zero;                 // Most R-type and shifts
  logic       funct7Alt;                  // sub, sra, srai
  logic       opImmLegal;
  logic       opLegal;
  logic       loadLegal;
  logic       storeLegal;
  logic       branchLegal;
  logic       jalrLegal;
  logic       legal;
  logic       subOp;
  logic       sraOp;
  logic       sltOp;
  decodeCtrlT base;                       // Controls before field fill-in

  // Packs the opcode-level part of the control word
  function automatic decodeCtrlT ctrlWord(
    input logic      regWrite,
    input immSrcE    immSrc,
    input logic      aluSrcA,
    input logic      aluSrcB,
    input logic      memRead,
    input logic      memWrite,
    input resultSrcE resultSrc,
    input logic      branch,
    input logic      jump,
    input logic      aluOp
  );
    decodeCtrlT w;
    w           = '0;
    w.regWrite  = regWrite;
    w.immSrc    = immSrc;
    w.aluSrcA   = aluSrcA;
    w.aluSrcB   = aluSrcB;
    w.memRead   = memRead;
    w.memWrite  = memWrite;
    w.resultSrc = resultSrc;
    w.branch    = branch;
    w.jump      = jump;
    w.aluOp     = aluOp;
    return w;
  endfunction

  assign opcode = opcodeE'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  ////////////////////////////////////////////////////////////
  // Legality per major opcode
  ////////////////////////////////////////////////////////////

  assign funct7Zero  = (funct7 == 7'b0000000);
  assign funct7Alt   = (funct7 == 7'b0100000);
  assign opImmLegal  = (funct3 == 3'b001) ? funct7Zero :               // slli
                       (funct3 == 3'b101) ? (funct7Zero | funct7Alt) : // srli, srai
                       1'b1;
  assign opLegal     = funct7Zero | (funct7Alt & (funct3 == 3'b000 | funct3 == 3'b101));
  assign loadLegal   = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  assign storeLegal  = funct3 inside {3'b000, 3'b001, 3'b010};
  assign branchLegal = (funct3[2:1] != 2'b01);                       // 010 and 011 reserved
  assign jalrLegal   = (funct3 == 3'b000);

  // Main decode, one control word per opcode
  always_comb begin
    base  = '0;
    legal = 1'b0;
    case (opcode)
      opLoad:   begin
        legal = loadLegal;
        base  = ctrlWord(1'b1, immI, 1'b0, 1'b1, 1'b1, 1'b0, resMem, 1'b0, 1'b0, 1'b0);
      end
      opStore:  begin
        legal = storeLegal;
        base  = ctrlWord(1'b0, immS, 1'b0, 1'b1, 1'b0, 1'b1, resAlu, 1'b0, 1'b0, 1'b0);
      end
      opOpImm:  begin
        legal = opImmLegal;
        base  = ctrlWord(1'b1, immI, 1'b0, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b1);
      end
      opOp:     begin
        legal = opLegal;
        base  = ctrlWord(1'b1, immI, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b1);
      end
      opLui:    begin
        legal = 1'b1;
        base  = ctrlWord(1'b1, immU, 1'b0, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b0);
      end
      opAuipc:  begin
        legal = 1'b1;                     // PC + upper immediate
        base  = ctrlWord(1'b1, immU, 1'b1, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b0);
      end
      opBranch: begin
        legal = branchLegal;              // ALU forms the target
        base  = ctrlWord(1'b0, immB, 1'b1, 1'b1, 1'b0, 1'b0, resAlu, 1'b1, 1'b0, 1'b0);
      end
      opJal:    begin
        legal = 1'b1;
        base  = ctrlWord(1'b1, immJ, 1'b1, 1'b1, 1'b0, 1'b0, resPcPlus4, 1'b0, 1'b1, 1'b0);
      end
      opJalr:   begin
        legal = jalrLegal;                // Target from rs1 + imm
        base  = ctrlWord(1'b1, immI, 1'b0, 1'b1, 1'b0, 1'b0, resPcPlus4, 1'b0, 1'b1, 1'b0);
      end
      default:  legal = 1'b0;             // Unknown major opcode
    endcase
  end

  // instr[5] separates sub from addi
  assign subOp = (funct3 == 3'b000) & funct7[5] & instr[5];
  assign sraOp = (funct3 == 3'b101) & funct7[5];
  assign sltOp = (funct3 == 3'b010) | (funct3 == 3'b011);

  // Register fields are passed unqualified by format
  always_comb begin
    ctrl = '0;
    if (legal) begin
      ctrl          = base;
      ctrl.subArith = base.aluOp & (subOp | sraOp | sltOp);
      ctrl.funct3   = funct3;
      ctrl.funct7   = funct7;
      ctrl.rs1      = instr[19:15];
      ctrl.rs2      = instr[24:20];
      ctrl.rd       = instr[11:7];
      ctrl.valid    = 1'b1;
    end
  end

  assign illegal = ~legal;

  always_comb begin
    assert final (!(illegal && (ctrl.regWrite || ctrl.memWrite)))
      else $error("illegal instruction drives a register or memory write");
  end

endmodule

// ==== src/laneController.sv ====
/*
  Lane control unit top level
  Decoder, pipelined control registers and hazard unit
*/
`timescale 1ns/1ps

module laneController #(
  parameter int NumLanes = 4
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [31:0]                     instrD,
  input  logic                            stallD,
  input  logic                            flushD,
  input  logic                            stallE,
  input  logic                            flushE,
  input  logic                            stallM,
  input  logic                            flushM,
  input  logic                            stallW,
  input  logic                            flushW,
  input  logic [1:0]                      flagsE,      // {eq, lt}
  input  ctrlPkg::laneWrT [NumLanes-2:0]  otherMem,
  input  ctrlPkg::laneWrT [NumLanes-2:0]  otherWb,
  output ctrlPkg::decodeCtrlT             ctrlD,
  output logic                            illegalD,
  output ctrlPkg::decodeCtrlT             exCtrl,
  output ctrlPkg::memCtrlT                memCtrl,
  output ctrlPkg::wbCtrlT                 wbCtrl,
  output logic                            pcSrcE,
  output ctrlPkg::fwdSelE                 fwdA,
  output ctrlPkg::fwdSelE                 fwdB,
  output logic [$clog2(NumLanes)-1:0]     laneSelA,
  output logic [$clog2(NumLanes)-1:0]     laneSelB,
  output logic                            loadStallD
);

  instrDecoder decoder (
    .instr   (instrD),
    .ctrl    (ctrlD),
    .illegal (illegalD)
  );

  ctrlPipe pipe (
    .clk, .rstN,
    .stallD, .flushD, .stallE, .flushE,
    .stallM, .flushM, .stallW, .flushW,
    .ctrlD, .flagsE,
    .exCtrl, .memCtrl, .wbCtrl, .pcSrcE
  );

  hazardUnit #(.NumLanes(NumLanes)) hazard (
    .ctrlD, .exCtrl, .memCtrl, .wbCtrl,
    .otherMem, .otherWb,
    .fwdA, .fwdB, .laneSelA, .laneSelB,
    .loadStallD
  );

endmodule

// ==== tb.f ====
+incdir+verif
src/ctrlPkg.sv
src/instrDecoder.sv
src/ctrlPipe.sv
src/hazardUnit.sv
src/laneController.sv
verif/laneControllerTb.sv

// ==== verif/tbVectors.svh ====
/*
  Decode table with expected controls, flags and redirect,
  plus the sizes of the random phases
*/
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int RandCycles   = 80;         // Random stall/flush cycles
localparam int FwdScenarios = 60;
localparam int RegRange     = 4;          // Small register set so hazards collide

localparam expBitsT LoadB   = '{1'b1, immI, 1'b0, 1'b1, 1'b1, 1'b0, resMem, 1'b0, 1'b0, 1'b0, 1'b0};
localparam expBitsT StoreB  = '{1'b0, immS, 1'b0, 1'b1, 1'b0, 1'b1, resAlu, 1'b0, 1'b0, 1'b0, 1'b0};
localparam expBitsT ImmB    = '{1'b1, immI, 1'b0, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b1, 1'b0};
localparam expBitsT ImmSubB = '{1'b1, immI, 1'b0, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b1, 1'b1};
localparam expBitsT RegB    = '{1'b1, immI, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b1, 1'b0};
localparam expBitsT RegSubB = '{1'b1, immI, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b1, 1'b1};
localparam expBitsT LuiB    = '{1'b1, immU, 1'b0, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b0, 1'b0};
localparam expBitsT AuipcB  = '{1'b1, immU, 1'b1, 1'b1, 1'b0, 1'b0, resAlu, 1'b0, 1'b0, 1'b0, 1'b0};
localparam expBitsT JalB    = '{1'b1, immJ, 1'b1, 1'b1, 1'b0, 1'b0, resPcPlus4, 1'b0, 1'b1, 1'b0, 1'b0};
localparam expBitsT JalrB   = '{1'b1, immI, 1'b0, 1'b1, 1'b0, 1'b0, resPcPlus4, 1'b0, 1'b1, 1'b0, 1'b0};
localparam expBitsT BranchB = '{1'b0, immB, 1'b1, 1'b1, 1'b0, 1'b0, resAlu, 1'b1, 1'b0, 1'b0, 1'b0};

task automatic buildTable();
  logic [2:0] brF3[6];
  brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  addRow(enc(7'h00, 5'd4, 5'd1, 3'b010, 5'd5, opLoad), LoadB, 2'b00);      // lw
  addRow(enc(7'h7f, 5'd31, 5'd2, 3'b100, 5'd6, opLoad), LoadB, 2'b11);    // lbu, negative offset
  addBad(enc(7'h00, 5'd0, 5'd1, 3'b011, 5'd5, opLoad));                   // ld is RV64
  addRow(enc(7'h01, 5'd7, 5'd3, 3'b010, 5'd8, opStore), StoreB, 2'b00);
  addBad(enc(7'h01, 5'd7, 5'd3, 3'b011, 5'd8, opStore));
  addRow(enc(7'h25, 5'd9, 5'd1, 3'b000, 5'd2, opOpImm), ImmB, 2'b10);     // addi, imm bit 10 set
  addRow(enc(7'h00, 5'd3, 5'd1, 3'b010, 5'd2, opOpImm), ImmSubB, 2'b00);  // slti
  addRow(enc(7'h7f, 5'd3, 5'd1, 3'b011, 5'd2, opOpImm), ImmSubB, 2'b00);  // sltiu
  addRow(enc(7'h40, 5'd3, 5'd1, 3'b100, 5'd2, opOpImm), ImmB, 2'b00);     // xori
  addRow(enc(7'h00, 5'd3, 5'd1, 3'b001, 5'd2, opOpImm), ImmB, 2'b00);     // slli
  addBad(enc(7'h20, 5'd3, 5'd1, 3'b001, 5'd2, opOpImm));
  addRow(enc(7'h00, 5'd3, 5'd1, 3'b101, 5'd2, opOpImm), ImmB, 2'b00);     // srli
  addRow(enc(7'h20, 5'd3, 5'd1, 3'b101, 5'd2, opOpImm), ImmSubB, 2'b00);  // srai
  addBad(enc(7'h10, 5'd3, 5'd1, 3'b101, 5'd2, opOpImm));
  addRow(enc(7'h00, 5'd3, 5'd1, 3'b000, 5'd2, opOp), RegB, 2'b00);        // add
  addRow(enc(7'h20, 5'd3, 5'd1, 3'b000, 5'd2, opOp), RegSubB, 2'b00);     // sub
  addRow(enc(7'h00, 5'd3, 5'd1, 3'b001, 5'd2, opOp), RegB, 2'b00);        // sll
  addRow(enc(7'h20, 5'd3, 5'd1, 3'b101, 5'd2, opOp), RegSubB, 2'b00);     // sra
  addRow(enc(7'h00, 5'd3, 5'd1, 3'b011, 5'd2, opOp), RegSubB, 2'b00);     // sltu
  addBad(enc(7'h20, 5'd3, 5'd1, 3'b111, 5'd2, opOp));
  addBad(enc(7'h01, 5'd3, 5'd1, 3'b000, 5'd2, opOp));                     // mul
  addRow(enc(7'h12, 5'd3, 5'd4, 3'b101, 5'd7, opLui), LuiB, 2'b00);
  addRow(enc(7'h12, 5'd3, 5'd4, 3'b101, 5'd7, opAuipc), AuipcB, 2'b00);
  addRow(enc(7'h02, 5'd8, 5'd0, 3'b000, 5'd1, opJal), JalB, 2'b00);
  addRow(enc(7'h00, 5'd8, 5'd6, 3'b000, 5'd1, opJalr), JalrB, 2'b01);
  addBad(enc(7'h00, 5'd8, 5'd6, 3'b001, 5'd1, opJalr));
  foreach (brF3[i]) begin
    for (int f = 0; f < 4; f++) begin
      addRow(enc(7'h00, 5'd2, 5'd1, brF3[i], 5'd8, opBranch), BranchB, 2'(f));
    end
  end
  addBad(enc(7'h00, 5'd2, 5'd1, 3'b010, 5'd8, opBranch));
  addBad(enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, 7'h0f));                   // fence
  addBad(enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, 7'h73));                   // system
  addBad(enc(7'h7f, 5'd31, 5'd31, 3'b111, 5'd31, 7'h7f));
endtask

`endif

// ==== verif/laneControllerTb.sv ====
/*
  Lane controller testbench: clock, reset, table-driven decode and
  pipeline checks, random stall/flush, forwarding and load-use checks
*/
`timescale 1ns/1ps

module laneControllerTb;
  import ctrlPkg::*;

  localparam int NumLanes = 4;

  // Opcode-level part of an expected control word
  typedef struct packed {
    logic      rw;
    immSrcE    imm;
    logic      a;
    logic      b;
    logic      mr;
    logic      mw;
    resultSrcE res;
    logic      br;
    logic      j;
    logic      op;
    logic      sub;
  } expBitsT;

  typedef struct packed {
    logic [31:0] instr;
    decodeCtrlT  exp;
    logic        illegal;
    logic [1:0]  flags;                   // {eq, lt} while the row sits in Execute
    logic        pcSrc;
  } vecT;

  logic clk;
  logic rstN;
  logic [31:0] instrD;
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  logic [1:0] flagsE;
  laneWrT [NumLanes-2:0] otherMem;
  laneWrT [NumLanes-2:0] otherWb;
  decodeCtrlT ctrlD;
  decodeCtrlT exCtrl;
  memCtrlT memCtrl;
  wbCtrlT wbCtrl;
  logic illegalD, pcSrcE, loadStallD;
  fwdSelE fwdA, fwdB;
  logic [$clog2(NumLanes)-1:0] laneSelA, laneSelB;

  vecT tbl[$];
  int unsigned seed;
  decodeCtrlT expE;                       // Reference stage contents
  memCtrlT expM;
  wbCtrlT expW;
  logic validDExp;                        // Reference Decode occupancy
  int exRow;                              // Table row in Execute, -1 for bubble
  int lastRow;
  logic [7:0] lastSf;                     // {stallD, flushD, stallE, flushE, stallM, ...}

  laneController #(.NumLanes(NumLanes)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog for the whole run
  initial begin
    #5ms;
    $display("Simulation did not finish within the time limit");
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

  function automatic int unsigned nextRand(input int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 8) % n;
  endfunction

  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Taken condition per branch mnemonic
  function automatic logic branchTaken(input logic [2:0] f3, input logic [1:0] flags);
    logic eq;
    logic lt;
    logic taken;
    eq = flags[1];
    lt = flags[0];
    case (f3)
      3'b000:  taken = eq;                // beq
      3'b001:  taken = !eq;               // bne
      3'b100:  taken = lt;                // blt
      3'b101:  taken = !lt;               // bge
      3'b110:  taken = lt;                // bltu
      3'b111:  taken = !lt;               // bgeu
      default: taken = 1'b0;
    endcase
    return taken;
  endfunction

  task automatic addRow(input logic [31:0] i, input expBitsT b, input logic [1:0] flags);
    vecT v;
    v                  = '0;
    v.instr            = i;
    v.exp.regWrite     = b.rw;
    v.exp.immSrc       = b.imm;
    v.exp.aluSrcA      = b.a;
    v.exp.aluSrcB      = b.b;
    v.exp.memRead      = b.mr;
    v.exp.memWrite     = b.mw;
    v.exp.resultSrc    = b.res;
    v.exp.branch       = b.br;
    v.exp.jump         = b.j;
    v.exp.aluOp        = b.op;
    v.exp.subArith     = b.sub;
    v.exp.funct3       = i[14:12];
    v.exp.funct7       = i[31:25];
    v.exp.rs1          = i[19:15];
    v.exp.rs2          = i[24:20];
    v.exp.rd           = i[11:7];
    v.exp.valid        = 1'b1;
    v.flags            = flags;
    v.pcSrc            = b.j | (b.br & branchTaken(i[14:12], flags));
    tbl.push_back(v);
  endtask

  task automatic addBad(input logic [31:0] i);
    vecT v;
    v         = '0;                       // Illegal rows carry zero controls
    v.instr   = i;
    v.illegal = 1'b1;
    tbl.push_back(v);
  endtask

  function automatic memCtrlT toMem(input decodeCtrlT c);
    memCtrlT m;
    m.regWrite  = c.regWrite;
    m.memRead   = c.memRead;
    m.memWrite  = c.memWrite;
    m.resultSrc = c.resultSrc;
    m.funct3    = c.funct3;
    m.rd        = c.rd;
    m.valid     = c.valid;
    return m;
  endfunction

  function automatic wbCtrlT toWb(input memCtrlT m);
    wbCtrlT w;
    w.regWrite  = m.regWrite;
    w.resultSrc = m.resultSrc;
    w.rd        = m.rd;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic reportMismatch(input string n, input logic [63:0] got, input logic [63:0] exp);
    $display("ERROR %s: got %h expected %h", n, got, exp);
    $display("** FAIL **");
    $fatal(1, "mismatch on %s", n);
  endtask

  task automatic checkDecode(input string n, input decodeCtrlT got, input decodeCtrlT exp);
    if (got !== exp) reportMismatch(n, 64'(got), 64'(exp));
  endtask

  task automatic checkMem(input string n, input memCtrlT got, input memCtrlT exp);
    if (got !== exp) reportMismatch(n, 64'(got), 64'(exp));
  endtask

  task automatic checkWb(input string n, input wbCtrlT got, input wbCtrlT exp);
    if (got !== exp) reportMismatch(n, 64'(got), 64'(exp));
  endtask

  task automatic checkFwd(input string n, input fwdSelE got, input fwdSelE exp);
    if (got !== exp) reportMismatch(n, 64'(got), 64'(exp));
  endtask

  task automatic checkBit(input string n, input logic got, input logic exp);
    if (got !== exp) reportMismatch(n, 64'(got), 64'(exp));
  endtask

  task automatic checkLane(input string n, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) reportMismatch(n, 64'(got), 64'(exp));
  endtask

  `include "tbVectors.svh"

  ////////////////////////////////////////////////////////////
  // One clock of the pipeline with the reference stage model
  ////////////////////////////////////////////////////////////

  task automatic stepPipe(input int row, input logic [7:0] sf);
    decodeCtrlT rowCtrl;
    @(negedge clk);
    rowCtrl = (lastRow >= 0 && validDExp) ? tbl[lastRow].exp : '0;  // Bubble after flushD
    expW  = lastSf[0] ? '0 : lastSf[1] ? expW : toWb(expM);   // Flush beats stall
    expM  = lastSf[2] ? '0 : lastSf[3] ? expM : toMem(expE);
    expE  = lastSf[4] ? '0 : lastSf[5] ? expE : rowCtrl;
    exRow = lastSf[4] ? -1 : lastSf[5] ? exRow : (validDExp ? lastRow : -1);
    validDExp = lastSf[6] ? 1'b0 : lastSf[7] ? validDExp : 1'b1;
    checkDecode("exCtrl", exCtrl, expE);
    checkMem("memCtrl", memCtrl, expM);
    checkWb("wbCtrl", wbCtrl, expW);
    instrD = (row >= 0) ? tbl[row].instr : 32'h0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = sf;
    flagsE = (exRow >= 0) ? tbl[exRow].flags : 2'b00;
    #1;
    checkDecode("ctrlD", ctrlD, (row >= 0) ? tbl[row].exp : '0);
    checkBit("illegalD", illegalD, (row >= 0) ? tbl[row].illegal : 1'b1);
    checkBit("pcSrcE", pcSrcE, (exRow >= 0) ? tbl[exRow].pcSrc : 1'b0);
    lastRow = row;
    lastSf  = sf;
  endtask

  // First match wins: own Mem, other Mem, own Wb, other Wb
  function automatic void expectFwd(input logic [4:0] rs, input logic rwM, input logic [4:0] rdM,
                                    input logic rwW, input logic [4:0] rdW,
                                    input laneWrT [NumLanes-2:0] oM,
                                    input laneWrT [NumLanes-2:0] oW,
                                    output fwdSelE sel, output logic [1:0] lane);
    sel  = fwdNone;
    lane = 2'd0;
    if (rs == 5'd0) return;
    if (rwM && rdM == rs) begin
      sel = fwdMem;
      return;
    end
    for (int k = 0; k < NumLanes - 1; k++) begin
      if (oM[k].regWrite && oM[k].rd == rs) begin
        sel  = fwdMem;
        lane = 2'(k + 1);
        return;
      end
    end
    if (rwW && rdW == rs) begin
      sel = fwdWb;
      return;
    end
    for (int k = 0; k < NumLanes - 1; k++) begin
      if (oW[k].regWrite && oW[k].rd == rs) begin
        sel  = fwdWb;
        lane = 2'(k + 1);
        return;
      end
    end
  endfunction

  task automatic fwdScenario();
    logic [4:0] rdW, rdM, rdE, rs1E, rs2E, rs1D, rs2D;
    logic rwW, rwM, loadE;
    laneWrT [NumLanes-2:0] oM, oW;
    fwdSelE sel;
    logic [1:0] lane;
    logic [31:0] seq[4];
    rdW  = 5'(nextRand(RegRange));
    rdM  = 5'(nextRand(RegRange));
    rdE  = 5'(nextRand(RegRange));
    rs1E = 5'(nextRand(RegRange));
    rs2E = 5'(nextRand(RegRange));
    rs1D = 5'(nextRand(RegRange));
    rs2D = 5'(nextRand(RegRange));
    rwW   = nextRand(2) == 1;
    rwM   = nextRand(2) == 1;
    loadE = nextRand(2) == 1;
    for (int k = 0; k < NumLanes - 1; k++) begin
      oM[k] = '{rd: 5'(nextRand(RegRange)), regWrite: nextRand(2) == 1};
      oW[k] = '{rd: 5'(nextRand(RegRange)), regWrite: nextRand(2) == 1};
    end
    // Stores keep an rd field but never write
    seq[0] = rwW ? enc(7'h0, 5'd1, 5'd2, 3'b000, rdW, opOp)
                 : enc(7'h0, 5'd1, 5'd2, 3'b010, rdW, opStore);
    seq[1] = rwM ? enc(7'h0, 5'd1, 5'd2, 3'b000, rdM, opOp)
                 : enc(7'h0, 5'd1, 5'd2, 3'b010, rdM, opStore);
    seq[2] = loadE ? enc(7'h0, rs2E, rs1E, 3'b010, rdE, opLoad)
                   : enc(7'h0, rs2E, rs1E, 3'b000, rdE, opOp);
    seq[3] = enc(7'h0, rs2D, rs1D, 3'b000, 5'd9, opOp);
    @(negedge clk);
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = 8'b0;
    otherMem = '0;
    otherWb  = '0;
    instrD   = seq[0];
    for (int k = 1; k < 4; k++) begin
      @(negedge clk);
      instrD = seq[k];
    end
    otherMem = oM;
    otherWb  = oW;
    #1;
    expectFwd(rs1E, rwM, rdM, rwW, rdW, oM, oW, sel, lane);
    checkFwd("fwdA", fwdA, sel);
    checkLane("laneSelA", laneSelA, lane);
    expectFwd(rs2E, rwM, rdM, rwW, rdW, oM, oW, sel, lane);
    checkFwd("fwdB", fwdB, sel);
    checkLane("laneSelB", laneSelB, lane);
    checkBit("loadStallD", loadStallD, loadE && rdE != 5'd0 && (rdE == rs1D || rdE == rs2D));
  endtask

  initial begin
    int n;
    logic [7:0] sf;
    seed   = 95416;
    rstN   = 1'b0;
    instrD = 32'h0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = 8'b0;
    flagsE   = 2'b00;
    otherMem = '0;
    otherWb  = '0;
    expE = '0;
    expM = '0;
    expW = '0;
    validDExp = 1'b0;
    exRow   = -1;
    lastRow = -1;
    lastSf  = 8'b0;
    buildTable();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    n = 0;
    while ((exCtrl !== '0 || memCtrl !== '0 || wbCtrl !== '0) && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (n >= 8) begin
      $display("Stage registers did not clear after reset");
      $display("** FAIL **");
      $fatal(1, "reset");
    end
    repeat (2) stepPipe(-1, 8'b0);
    foreach (tbl[i]) stepPipe(i, 8'b0);  // Straight flow, 1/2/3 cycle latency
    repeat (3) stepPipe(-1, 8'b0);
    repeat (RandCycles) begin
      for (int b = 0; b < 8; b++) sf[b] = (nextRand(4) == 0);
      stepPipe(int'(nextRand(tbl.size())), sf);
    end
    repeat (3) stepPipe(-1, 8'b0);
    repeat (FwdScenarios) fwdScenario();
    $display("** PASS **");
    $finish;
  end

endmodule
